// File: Makefile
TOP = tb_cpu_top

.PHONY: sim clean

sim:
	verilator --binary --timing --top-module $(TOP) -f cpu_top.f -o vsim
	out=$$(./obj_dir/vsim); echo "$$out"; echo "$$out" | grep -q "^TESTBENCH PASSED$$"

clean:
	rm -rf obj_dir

// File: cpu_bus_pkg.sv
`default_nettype none

package cpu_bus_pkg;

  import cpu_isa_pkg::*;

  // --------------------
  // Datapath words
  // --------------------
  localparam int XLEN    = 19;
  localparam int SHAMT_W = 5;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [XLEN-1:0] addr_t;

  // First fetch address after reset
  localparam addr_t RESET_PC    = 19'h100;
  // Byte step between instructions
  localparam addr_t INSTR_BYTES = 19'd4;

  // Register write-back source
  typedef enum logic [1:0] {
    WB_ALU = 2'd0,
    WB_MEM = 2'd1,
    WB_IMM = 2'd2,
    WB_PC4 = 2'd3
  } wb_sel_e;

  // --------------------
  // Control bundle
  // --------------------
  typedef struct packed {
    alu_op_e    alu_op;
    logic       op1_pc;     // operand A is the PC
    logic       op2_imm;    // operand B is the immediate
    logic       is_branch;
    branch_op_e branch_op;
    logic       is_jump;
    logic       mem_req;
    logic       mem_wr;
    logic       rf_wr_en;
    wb_sel_e    wb_sel;
    reg_addr_t  rd;
  } ctrl_t;

  // All enables low, behaves as a no-op
  localparam ctrl_t CTRL_NOP = '{
    alu_op:    ALU_ADD,
    op1_pc:    1'b0,
    op2_imm:   1'b0,
    is_branch: 1'b0,
    branch_op: BR_EQ,
    is_jump:   1'b0,
    mem_req:   1'b0,
    mem_wr:    1'b0,
    rf_wr_en:  1'b0,
    wb_sel:    WB_ALU,
    rd:        '0
  };

  // Data memory request
  typedef struct packed {
    logic  req;
    logic  wr;
    addr_t addr;
    word_t wr_data;
  } dmem_req_t;

endpackage

`default_nettype wire

// File: cpu_golden.hex
// Words 0-62 program from 0x100, word 63 halt address
// Then pairs of store address and data, ended by 7ffff
0f080 09019 0a1fd 03280 18ec0 04288 18f04 052b8
18f48 032a0 18ecc 0e004 043a8 18f10 055b0 18f54
03290 04798 18f18 2dabc 18f5c 0fe40 11fc8 18e40
20d82 18ec4 21cc2 18ec8 22582 18ecc 23c82 18ed0
20cc2 18f84 21d82 18e88 22c82 18ecc 23582 18f10
35002 18ed4 18f54 30000 00000 00000 00000 00000
00000 00000 00000 00000 00000 00000 00000 00000
00000 00000 00000 00000 00000 00000 00000 001ac
00080 00016 00084 0001c 00088 7ffb5 0008c 7ffe4
00090 00190 00094 07fff 00098 0001d 0009c 55e00
000c0 7ffb5 000c4 00004 000c8 7fffd 000cc 00019
000d0 0001d 000d4 001a4 7ffff

// File: cpu_isa_pkg.sv
`default_nettype none

package cpu_isa_pkg;

  // --------------------
  // Field widths
  // --------------------
  localparam int OPCODE_W   = 4;
  localparam int REG_ADDR_W = 3;
  localparam int FUNCT3_W   = 3;
  localparam int INSTR_W    = 19;

  // Register count follows from the index width
  localparam int NUM_REGS = 1 << REG_ADDR_W;

  // --------------------
  // Field positions
  // --------------------
  // Low bit of each field inside the instruction word
  localparam int OPCODE_POS = 15;
  localparam int RD_POS     = 12;
  localparam int RS1_POS    = 9;
  localparam int RS2_POS    = 6;
  localparam int FUNCT3_POS = 3;

  // Immediate widths, all taken from bit 0 upwards
  localparam int IMM_I_W = 9;   // ADDI and load
  localparam int IMM_S_W = 6;   // store and branch
  localparam int IMM_U_W = 12;  // upper immediate and jump

  // --------------------
  // Types
  // --------------------
  typedef logic [INSTR_W-1:0]    instr_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  typedef enum logic [OPCODE_W-1:0] {
    OP_ALU    = 4'h0,
    OP_ADDI   = 4'h1,
    OP_LOAD   = 4'h2,
    OP_STORE  = 4'h3,
    OP_BRANCH = 4'h4,
    OP_LUI    = 4'h5,
    OP_JAL    = 4'h6
  } opcode_e;

  // Same encoding as funct3 of a register-register op
  typedef enum logic [FUNCT3_W-1:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SLL = 3'd5,
    ALU_SRL = 3'd6,
    ALU_MUL = 3'd7
  } alu_op_e;

  // Carried in the rd field of a branch
  typedef enum logic [REG_ADDR_W-1:0] {
    BR_EQ = 3'd0,
    BR_NE = 3'd1,
    BR_LT = 3'd2,
    BR_GE = 3'd3
  } branch_op_e;

endpackage

`default_nettype wire

// File: cpu_top.f
cpu_isa_pkg.sv
cpu_bus_pkg.sv
fetch_unit.sv
decode_control.sv
regfile.sv
execute_unit.sv
load_store_wb.sv
cpu_top.sv
tb_cpu_top.sv

// File: cpu_top.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_top
  import cpu_isa_pkg::*;
  import cpu_bus_pkg::*;
(
  input  wire logic   clk,
  input  wire logic   reset_n,

  // Instruction memory
  output logic        instr_mem_req_o,
  output addr_t       instr_mem_addr_o,
  input  wire instr_t instr_mem_rd_data_i,

  // Data memory
  output logic        data_mem_req_o,
  output addr_t       data_mem_addr_o,
  output logic        data_mem_wr_o,
  output word_t       data_mem_wr_data_o,
  input  wire word_t  data_mem_rd_data_i
);

  // --------------------
  // Internal signals
  // --------------------
  logic      started;
  addr_t     pc;
  word_t     pc_plus4;
  logic      redirect;
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  word_t     imm;
  ctrl_t     ctrl;
  word_t     rs1_data;
  word_t     rs2_data;
  word_t     alu_res;
  logic      branch_taken;
  dmem_req_t dmem_req;
  logic      rf_wr_en;
  word_t     rf_wr_data;

  // Single point where a PC redirect is decided
  assign redirect = branch_taken | ctrl.is_jump;

  // --------------------
  // Fetch
  // --------------------
  fetch_unit u_fetch_unit (
    .clk              (clk),
    .reset_n          (reset_n),
    .redirect_i       (redirect),
    .target_i         (alu_res),
    .started_o        (started),
    .pc_o             (pc),
    .pc_plus4_o       (pc_plus4),
    .instr_mem_req_o  (instr_mem_req_o),
    .instr_mem_addr_o (instr_mem_addr_o)
  );

  // --------------------
  // Decode
  // --------------------
  decode_control u_decode_control (
    .instr_i (instr_mem_rd_data_i),
    .rs1_o   (rs1_addr),
    .rs2_o   (rs2_addr),
    .imm_o   (imm),
    .ctrl_o  (ctrl)
  );

  // Write port driven by write-back below
  regfile u_regfile (
    .clk        (clk),
    .reset_n    (reset_n),
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .rd_addr_i  (ctrl.rd),
    .wr_en_i    (rf_wr_en),
    .wr_data_i  (rf_wr_data),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  // --------------------
  // Execute
  // --------------------
  execute_unit u_execute_unit (
    .ctrl_i         (ctrl),
    .pc_i           (pc),
    .rs1_data_i     (rs1_data),
    .rs2_data_i     (rs2_data),
    .imm_i          (imm),
    .alu_res_o      (alu_res),
    .branch_taken_o (branch_taken)
  );

  // --------------------
  // Memory and write-back
  // --------------------
  load_store_wb u_load_store_wb (
    .ctrl_i        (ctrl),
    .started_i     (started),
    .alu_res_i     (alu_res),
    .rs2_data_i    (rs2_data),
    .imm_i         (imm),
    .pc_plus4_i    (pc_plus4),
    .mem_rd_data_i (data_mem_rd_data_i),
    .dmem_o        (dmem_req),
    .rf_wr_en_o    (rf_wr_en),
    .rf_wr_data_o  (rf_wr_data)
  );

  // Request struct out to the pins
  assign data_mem_req_o     = dmem_req.req;
  assign data_mem_wr_o      = dmem_req.wr;
  assign data_mem_addr_o    = dmem_req.addr;
  assign data_mem_wr_data_o = dmem_req.wr_data;

endmodule

`default_nettype wire

// File: decode_control.sv
`timescale 1ns/100ps
`default_nettype none

module decode_control
  import cpu_isa_pkg::*;
  import cpu_bus_pkg::*;
(
  input  wire instr_t instr_i,
  output reg_addr_t   rs1_o,
  output reg_addr_t   rs2_o,
  output word_t       imm_o,
  output ctrl_t       ctrl_o
);

  opcode_e   opcode;
  reg_addr_t rd;
  logic [FUNCT3_W-1:0] funct3;

  word_t imm_i_type;
  word_t imm_s_type;
  word_t imm_b_type;
  word_t imm_u_type;
  word_t imm_j_type;

  // --------------------
  // Field extraction
  // --------------------
  assign opcode = opcode_e'(instr_i[OPCODE_POS +: OPCODE_W]);
  assign rd     = instr_i[RD_POS +: REG_ADDR_W];
  assign rs1_o  = instr_i[RS1_POS +: REG_ADDR_W];
  assign rs2_o  = instr_i[RS2_POS +: REG_ADDR_W];
  assign funct3 = instr_i[FUNCT3_POS +: FUNCT3_W];

  // --------------------
  // Immediates
  // --------------------
  // ADDI and load offset
  assign imm_i_type = {{(XLEN-IMM_I_W){instr_i[IMM_I_W-1]}}, instr_i[IMM_I_W-1:0]};
  // Store offset
  assign imm_s_type = {{(XLEN-IMM_S_W){instr_i[IMM_S_W-1]}}, instr_i[IMM_S_W-1:0]};
  // Branch offset in instruction words
  assign imm_b_type = {{(XLEN-IMM_S_W-2){instr_i[IMM_S_W-1]}}, instr_i[IMM_S_W-1:0], 2'b00};
  // Upper immediate lands in bits 18 to 7
  assign imm_u_type = {instr_i[IMM_U_W-1:0], {(XLEN-IMM_U_W){1'b0}}};
  // Jump offset in instruction words
  assign imm_j_type = {{(XLEN-IMM_U_W-2){instr_i[IMM_U_W-1]}}, instr_i[IMM_U_W-1:0], 2'b00};

  // --------------------
  // Control per opcode
  // --------------------
  always_comb begin
    ctrl_o = CTRL_NOP;
    imm_o  = imm_i_type;
    case (opcode)
      OP_ALU: begin
        ctrl_o.alu_op   = alu_op_e'(funct3);
        ctrl_o.rf_wr_en = 1'b1;
        ctrl_o.rd       = rd;
      end
      OP_ADDI: begin
        ctrl_o.op2_imm  = 1'b1;
        ctrl_o.rf_wr_en = 1'b1;
        ctrl_o.rd       = rd;
      end
      OP_LOAD: begin
        // Address is rs1 plus offset
        ctrl_o.op2_imm  = 1'b1;
        ctrl_o.mem_req  = 1'b1;
        ctrl_o.rf_wr_en = 1'b1;
        ctrl_o.wb_sel   = WB_MEM;
        ctrl_o.rd       = rd;
      end
      OP_STORE: begin
        ctrl_o.op2_imm = 1'b1;
        ctrl_o.mem_req = 1'b1;
        ctrl_o.mem_wr  = 1'b1;
        imm_o          = imm_s_type;
      end
      OP_BRANCH: begin
        // ALU forms PC plus offset, comparator decides
        ctrl_o.op1_pc    = 1'b1;
        ctrl_o.op2_imm   = 1'b1;
        ctrl_o.is_branch = 1'b1;
        ctrl_o.branch_op = branch_op_e'(rd);
        imm_o            = imm_b_type;
      end
      OP_LUI: begin
        ctrl_o.rf_wr_en = 1'b1;
        ctrl_o.wb_sel   = WB_IMM;
        ctrl_o.rd       = rd;
        imm_o           = imm_u_type;
      end
      OP_JAL: begin
        // Link register gets PC+4
        ctrl_o.op1_pc   = 1'b1;
        ctrl_o.op2_imm  = 1'b1;
        ctrl_o.is_jump  = 1'b1;
        ctrl_o.rf_wr_en = 1'b1;
        ctrl_o.wb_sel   = WB_PC4;
        ctrl_o.rd       = rd;
        imm_o           = imm_j_type;
      end
      default: begin
        // Unknown opcode stays a no-op
        ctrl_o = CTRL_NOP;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: execute_unit.sv
`timescale 1ns/100ps
`default_nettype none

module execute_unit
  import cpu_isa_pkg::*;
  import cpu_bus_pkg::*;
(
  input  wire ctrl_t ctrl_i,
  input  wire addr_t pc_i,
  input  wire word_t rs1_data_i,
  input  wire word_t rs2_data_i,
  input  wire word_t imm_i,
  output word_t      alu_res_o,
  output logic       branch_taken_o
);

  word_t opr_a;
  word_t opr_b;
  logic [SHAMT_W-1:0] shamt;
  logic  is_eq;
  logic  is_lt;
  logic  cond_met;

  // --------------------
  // Operand muxes
  // --------------------
  assign opr_a = ctrl_i.op1_pc  ? pc_i  : rs1_data_i;
  assign opr_b = ctrl_i.op2_imm ? imm_i : rs2_data_i;
  assign shamt = opr_b[SHAMT_W-1:0];

  // --------------------
  // ALU
  // --------------------
  always_comb begin
    case (ctrl_i.alu_op)
      ALU_ADD: alu_res_o = opr_a + opr_b;
      ALU_SUB: alu_res_o = opr_a - opr_b;
      ALU_AND: alu_res_o = opr_a & opr_b;
      ALU_OR:  alu_res_o = opr_a | opr_b;
      ALU_XOR: alu_res_o = opr_a ^ opr_b;
      ALU_SLL: alu_res_o = opr_a << shamt;
      ALU_SRL: alu_res_o = opr_a >> shamt;
      // Product truncated to the word
      ALU_MUL: alu_res_o = opr_a * opr_b;
      default: alu_res_o = opr_a + opr_b;
    endcase
  end

  // --------------------
  // Branch compare
  // --------------------
  // Always on register data, never on the muxed operands
  assign is_eq = (rs1_data_i == rs2_data_i);
  assign is_lt = ($signed(rs1_data_i) < $signed(rs2_data_i));

  always_comb begin
    case (ctrl_i.branch_op)
      BR_EQ:   cond_met = is_eq;
      BR_NE:   cond_met = !is_eq;
      BR_LT:   cond_met = is_lt;
      BR_GE:   cond_met = !is_lt;
      default: cond_met = 1'b0;
    endcase
  end

  assign branch_taken_o = ctrl_i.is_branch & cond_met;

endmodule

`default_nettype wire

// File: fetch_unit.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_unit
  import cpu_bus_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  reset_n,
  input  wire logic  redirect_i,
  input  wire addr_t target_i,
  output logic       started_o,
  output addr_t      pc_o,
  output word_t      pc_plus4_o,
  output logic       instr_mem_req_o,
  output addr_t      instr_mem_addr_o
);

  logic  started_q;
  addr_t pc_q;
  addr_t pc_seq;
  addr_t pc_nxt;

  // --------------------
  // Started flag
  // --------------------
  // First edge out of reset only raises this
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      started_q <= 1'b0;
    end else begin
      started_q <= 1'b1;
    end
  end

  // --------------------
  // Next PC
  // --------------------
  assign pc_seq = pc_q + INSTR_BYTES;

  // Taken branch or jump, target kept half-word aligned
  assign pc_nxt = redirect_i ? {target_i[XLEN-1:1], 1'b0} : pc_seq;

  // PC frozen until the idle cycle is over
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      pc_q <= RESET_PC;
    end else if (started_q) begin
      pc_q <= pc_nxt;
    end
  end

  // Outputs
  assign started_o        = started_q;
  assign pc_o             = pc_q;
  assign pc_plus4_o       = pc_seq;
  assign instr_mem_req_o  = started_q;
  assign instr_mem_addr_o = pc_q;

endmodule

`default_nettype wire

// File: load_store_wb.sv
`timescale 1ns/100ps
`default_nettype none

module load_store_wb
  import cpu_bus_pkg::*;
(
  input  wire ctrl_t ctrl_i,
  input  wire logic  started_i,
  input  wire word_t alu_res_i,
  input  wire word_t rs2_data_i,
  input  wire word_t imm_i,
  input  wire word_t pc_plus4_i,
  input  wire word_t mem_rd_data_i,
  output dmem_req_t  dmem_o,
  output logic       rf_wr_en_o,
  output word_t      rf_wr_data_o
);

  // --------------------
  // Data memory request
  // --------------------
  // Quiet in reset and in the idle first cycle
  assign dmem_o.req     = ctrl_i.mem_req & started_i;
  assign dmem_o.wr      = ctrl_i.mem_wr & started_i;
  assign dmem_o.addr    = alu_res_i;
  // Full-word store of rs2
  assign dmem_o.wr_data = rs2_data_i;

  // --------------------
  // Write-back
  // --------------------
  assign rf_wr_en_o = ctrl_i.rf_wr_en & started_i;

  always_comb begin
    case (ctrl_i.wb_sel)
      WB_ALU:  rf_wr_data_o = alu_res_i;
      // Read data arrives in the same cycle
      WB_MEM:  rf_wr_data_o = mem_rd_data_i;
      WB_IMM:  rf_wr_data_o = imm_i;
      WB_PC4:  rf_wr_data_o = pc_plus4_i;
      default: rf_wr_data_o = alu_res_i;
    endcase
  end

endmodule

`default_nettype wire

// File: regfile.sv
`timescale 1ns/100ps
`default_nettype none

module regfile
  import cpu_isa_pkg::*;
  import cpu_bus_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      reset_n,
  input  wire reg_addr_t rs1_addr_i,
  input  wire reg_addr_t rs2_addr_i,
  input  wire reg_addr_t rd_addr_i,
  input  wire logic      wr_en_i,
  input  wire word_t     wr_data_i,
  output word_t          rs1_data_o,
  output word_t          rs2_data_o
);

  word_t regs_q [NUM_REGS];

  // --------------------
  // Write port
  // --------------------
  // Register zero never written, so it stays at its reset value
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en_i && (rd_addr_i != '0)) begin
      regs_q[rd_addr_i] <= wr_data_i;
    end
  end

  // --------------------
  // Read ports
  // --------------------
  // Combinational, old value during a same-cycle write
  assign rs1_data_o = regs_q[rs1_addr_i];
  assign rs2_data_o = regs_q[rs2_addr_i];

endmodule

`default_nettype wire

// File: tb_cpu_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_cpu_top
  import cpu_isa_pkg::*;
  import cpu_bus_pkg::*;
;

  // --------------------
  // Run limits
  // --------------------
  localparam int CLK_HALF     = 20;
  localparam int CLK_PERIOD   = 2 * CLK_HALF;
  localparam int RESET_CYCLES = 5;
  localparam int PROG_LEN     = 63;
  localparam int HALT_IDX     = 63;
  localparam int PAIR_BASE    = 64;
  localparam int GOLDEN_DEPTH = 128;
  localparam int INSTR_BUDGET = 64;
  localparam int SLACK_CYCLES = 10;
  localparam int TAIL_CYCLES  = 4;
  // Reset, then every instruction once, then a margin
  localparam int WATCHDOG_NS  =
    (RESET_CYCLES + INSTR_BUDGET + SLACK_CYCLES) * CLK_PERIOD;
  localparam logic [18:0] END_MARK = 19'h7FFFF;
  // Store of r0 to address 0 shown on the bus while fetch is idle
  localparam instr_t IDLE_INSTR = {OP_STORE, 15'h0000};

  // DUT side
  logic   clk = 1'b0;
  logic   reset_n;
  logic   instr_mem_req_o;
  addr_t  instr_mem_addr_o;
  instr_t instr_rd;
  logic   data_mem_req_o;
  addr_t  data_mem_addr_o;
  logic   data_mem_wr_o;
  word_t  data_mem_wr_data_o;
  word_t  data_rd;

  // Models and golden data
  logic [18:0] golden_mem [0:GOLDEN_DEPTH-1];
  instr_t      imem [0:PROG_LEN-1];
  word_t       dmem [0:255];
  addr_t       halt_addr;

  // Checker state
  int     value_errors = 0;
  int     other_errors = 0;
  int     exp_idx      = PAIR_BASE;
  logic   started_seen = 1'b0;
  logic   have_prev    = 1'b0;
  addr_t  prev_addr;
  instr_t prev_instr;

  cpu_top uut (
    .clk                 (clk),
    .reset_n             (reset_n),
    .instr_mem_req_o     (instr_mem_req_o),
    .instr_mem_addr_o    (instr_mem_addr_o),
    .instr_mem_rd_data_i (instr_rd),
    .data_mem_req_o      (data_mem_req_o),
    .data_mem_addr_o     (data_mem_addr_o),
    .data_mem_wr_o       (data_mem_wr_o),
    .data_mem_wr_data_o  (data_mem_wr_data_o),
    .data_mem_rd_data_i  (data_rd)
  );

  always #(CLK_HALF) clk = ~clk;

  // Branch offset as a signed 6-bit word count
  function automatic addr_t branch_offset(input instr_t ins);
    branch_offset = {{11{ins[5]}}, ins[5:0], 2'b00};
  endfunction

  // Jump offset as a signed 12-bit word count
  function automatic addr_t jump_offset(input instr_t ins);
    jump_offset = {{5{ins[11]}}, ins[11:0], 2'b00};
  endfunction

  task automatic print_counts();
    $display("Errors: %0d value, %0d other", value_errors, other_errors);
  endtask

  // --------------------
  // Memory models
  // --------------------
  // Instruction word 1 ns after the edge
  always @(posedge clk) begin
    int    idx;
    addr_t off;
    #1;
    off = instr_mem_addr_o - RESET_PC;
    idx = int'(off >> 2);
    if (instr_mem_req_o && (off[1:0] == 2'b00) && (idx < PROG_LEN)) begin
      instr_rd = imem[idx];
    end else begin
      if (instr_mem_req_o) begin
        $display("Fetch at %0t outside the program, address %h", $time, instr_mem_addr_o);
        other_errors++;
      end
      instr_rd = IDLE_INSTR;
    end
  end

  // Read data 2 ns after the edge
  always @(posedge clk) begin
    #2;
    data_rd = dmem[data_mem_addr_o[9:2]];
  end

  // Store capture and compare against the trace
  always @(posedge clk) begin
    if (reset_n) begin
      started_seen <= 1'b1;
    end
    if (data_mem_req_o && data_mem_wr_o) begin
      dmem[data_mem_addr_o[9:2]] <= data_mem_wr_data_o;
      if (golden_mem[exp_idx] == END_MARK) begin
        $display("CHECK FAILED at %0t: extra store to %h data %h",
                 $time, data_mem_addr_o, data_mem_wr_data_o);
        value_errors++;
      end else begin
        if (data_mem_addr_o != golden_mem[exp_idx]) begin
          $display("CHECK FAILED at %0t: store address %h, expected %h",
                   $time, data_mem_addr_o, golden_mem[exp_idx]);
          value_errors++;
        end
        if (data_mem_wr_data_o != golden_mem[exp_idx+1]) begin
          $display("CHECK FAILED at %0t: store data %h, expected %h",
                   $time, data_mem_wr_data_o, golden_mem[exp_idx+1]);
          value_errors++;
        end
        exp_idx = exp_idx + 2;
      end
    end
  end

  // --------------------
  // Fetch monitor
  // --------------------
  // Sampled mid-cycle when all outputs have settled
  always @(negedge clk) begin
    if (!reset_n || !started_seen) begin
      // Quiet in reset and in the idle cycle
      if (instr_mem_req_o || data_mem_req_o || data_mem_wr_o) begin
        $display("CHECK FAILED at %0t: request high before start", $time);
        value_errors++;
      end
      if (instr_mem_addr_o != RESET_PC) begin
        $display("CHECK FAILED at %0t: fetch address %h, expected %h",
                 $time, instr_mem_addr_o, RESET_PC);
        value_errors++;
      end
    end else if (!instr_mem_req_o) begin
      $display("Fetch request dropped at %0t", $time);
      other_errors++;
    end else begin
      if (!have_prev) begin
        if (instr_mem_addr_o != RESET_PC) begin
          $display("CHECK FAILED at %0t: first fetch %h, expected %h",
                   $time, instr_mem_addr_o, RESET_PC);
          value_errors++;
        end
      end else if (prev_instr[18:15] == 4'h6) begin
        // Jump goes to its own address plus offset
        if (instr_mem_addr_o != prev_addr + jump_offset(prev_instr)) begin
          $display("CHECK FAILED at %0t: jump target %h from %h",
                   $time, instr_mem_addr_o, prev_addr);
          value_errors++;
        end
      end else if (prev_instr[18:15] == 4'h4) begin
        // Either fall through or take the offset
        if ((instr_mem_addr_o != prev_addr + 19'd4) &&
            (instr_mem_addr_o != prev_addr + branch_offset(prev_instr))) begin
          $display("CHECK FAILED at %0t: branch target %h from %h",
                   $time, instr_mem_addr_o, prev_addr);
          value_errors++;
        end
      end else if (instr_mem_addr_o != prev_addr + 19'd4) begin
        $display("CHECK FAILED at %0t: fetch %h after %h, expected step of 4",
                 $time, instr_mem_addr_o, prev_addr);
        value_errors++;
      end
      have_prev  <= 1'b1;
      prev_addr  <= instr_mem_addr_o;
      prev_instr <= instr_rd;
    end
  end

  // --------------------
  // Watchdog
  // --------------------
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout, program did not reach the halt address with all stores seen");
    other_errors++;
    print_counts();
    $display("TESTBENCH FAILED");
    $finish;
  end

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    reset_n  = 1'b0;
    instr_rd = IDLE_INSTR;
    data_rd  = '0;
    // Fill pattern over the full byte address
    for (int i = 0; i < 256; i++) begin
      dmem[i] = (19'(i) * 19'd4 * 19'h0013B) ^ 19'h2C5A5;
    end
    for (int i = 0; i < GOLDEN_DEPTH; i++) begin
      golden_mem[i] = END_MARK;
    end
    $readmemh("cpu_golden.hex", golden_mem);
    for (int i = 0; i < PROG_LEN; i++) begin
      imem[i] = golden_mem[i];
    end
    halt_addr = golden_mem[HALT_IDX];

    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset_n = 1'b1;

    // Run until trace is used up and fetch sits on the halt loop
    while (!((golden_mem[exp_idx] == END_MARK) && started_seen &&
             (instr_mem_addr_o == halt_addr))) begin
      @(negedge clk);
    end
    // Watch a few more cycles for stray stores
    repeat (TAIL_CYCLES) @(negedge clk);

    print_counts();
    if ((value_errors == 0) && (other_errors == 0)) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
